//--- src/dma_pkg.sv
////////////////////////////////////////////////////////////////////////////
// Shared widths, register map and bus structs of the descriptor DMA.
// Compiled first; RTL and testbench both use these types.
////////////////////////////////////////////////////////////////////////////

package dma_pkg;

  localparam int unsigned AddrWidth    = 32;
  localparam int unsigned DataWidth    = 32;
  localparam int unsigned LenWidth     = 16;
  localparam int unsigned CntWidth     = 16;
  localparam int unsigned RegAddrWidth = 4;

  typedef logic [AddrWidth-1:0]    addr_t;
  typedef logic [DataWidth-1:0]    data_t;
  typedef logic [LenWidth-1:0]     len_t;
  typedef logic [CntWidth-1:0]     cnt_t;
  typedef logic [RegAddrWidth-1:0] reg_addr_t;

  // Register word offsets
  localparam reg_addr_t RegDescAddr = 4'd0; // Write pushes a pointer
  localparam reg_addr_t RegStatus   = 4'd1;
  localparam reg_addr_t RegIrqClr   = 4'd2;
  localparam reg_addr_t RegDoneCnt  = 4'd3;

  // Descriptor word offsets
  localparam logic [1:0] DescSrc  = 2'd0;
  localparam logic [1:0] DescDst  = 2'd1;
  localparam logic [1:0] DescCtl  = 2'd2;
  localparam logic [1:0] DescNext = 2'd3;

  localparam int unsigned DescIrqBit = 31; // Interrupt enable in the control word

  typedef struct packed {
    logic  strobe;
    logic  we;
    addr_t addr;
    data_t wdata;
  } mem_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } mem_rsp_t;

  typedef struct packed {
    logic      wr;
    logic      rd;
    reg_addr_t addr;
    data_t     wdata;
  } reg_req_t;

  typedef struct packed {
    logic  rvalid;
    data_t rdata;
  } reg_rsp_t;

  typedef struct packed {
    addr_t src;
    addr_t dst;
    len_t  len;
  } xfer_t;

  typedef struct packed {
    logic        busy;
    logic        queue_full;
    logic        queue_empty;
    logic        irq;
    logic [11:0] reserved;
    cnt_t        done_cnt;
  } status_t;

endpackage

//--- src/dma_mem_arb.sv
////////////////////////////////////////////////////////////////////////////
// Fixed-priority merge of the backend and fetch memory masters onto one
// port. The backend always wins; read data goes back to its issuer only.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_mem_arb (
  input  logic              i_idma_backend,
  input  logic              rst_n_i,
  input  dma_pkg::mem_req_t be_req_i,
  output logic              be_gnt_o,
  output dma_pkg::mem_rsp_t be_rsp_o,
  input  dma_pkg::mem_req_t fe_req_i,
  output logic              fe_gnt_o,
  output dma_pkg::mem_rsp_t fe_rsp_o,
  output dma_pkg::mem_req_t mem_req_o,
  input  dma_pkg::mem_rsp_t mem_rsp_i
);
  import dma_pkg::*;

  logic owner_be_q; // Issuer of the last granted read

  assign be_gnt_o  = be_req_i.strobe;
  assign fe_gnt_o  = fe_req_i.strobe && !be_req_i.strobe;
  assign mem_req_o = be_req_i.strobe ? be_req_i : fe_req_i;

  always_ff @(posedge i_idma_backend or negedge rst_n_i) begin
    if (!rst_n_i) begin
      owner_be_q <= 1'b0;
    end else if (mem_req_o.strobe && !mem_req_o.we) begin
      owner_be_q <= be_gnt_o;
    end
  end

  always_comb begin
    be_rsp_o        = mem_rsp_i;
    fe_rsp_o        = mem_rsp_i;
    be_rsp_o.rvalid = mem_rsp_i.rvalid && owner_be_q;
    fe_rsp_o.rvalid = mem_rsp_i.rvalid && !owner_be_q;
  end

endmodule

//--- src/dma_backend.sv
////////////////////////////////////////////////////////////////////////////
// Word copy engine. For every word it reads the source, captures the data
// and writes it to the destination. Zero-length transfers skip memory.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_backend (
  input  logic              i_idma_backend,
  input  logic              rst_n_i,
  input  logic              xfer_start_i,
  input  dma_pkg::xfer_t    xfer_i,
  output logic              xfer_busy_o,
  output logic              xfer_done_o,
  output dma_pkg::mem_req_t mem_req_o,
  input  logic              mem_gnt_i,
  input  dma_pkg::mem_rsp_t mem_rsp_i
);
  import dma_pkg::*;

  typedef enum logic [2:0] {
    BeIdle,
    BeZero,
    BeRead,
    BeRwait,
    BeWrite
  } be_state_e;

  be_state_e state_q;
  len_t      rem_q;     // Words still to write
  addr_t     src_q, dst_q;
  data_t     data_q;
  logic      last_word;
  logic      start;
  logic      word_done;

  assign start     = (state_q == BeIdle) && xfer_start_i;
  assign last_word = (rem_q == len_t'(1));
  assign word_done = (state_q == BeWrite) && mem_gnt_i;

  always_ff @(posedge i_idma_backend or negedge rst_n_i) begin
    if (!rst_n_i) begin
      state_q <= BeIdle;
      rem_q   <= '0;
    end else begin
      case (state_q)
        BeIdle: begin
          if (xfer_start_i) begin
            rem_q   <= xfer_i.len;
            state_q <= (xfer_i.len == '0) ? BeZero : BeRead;
          end
        end
        BeZero: state_q <= BeIdle; // Done without touching memory
        BeRead: if (mem_gnt_i) state_q <= BeRwait;
        BeRwait: if (mem_rsp_i.rvalid) state_q <= BeWrite;
        BeWrite: begin
          if (mem_gnt_i) begin
            rem_q   <= rem_q - len_t'(1);
            state_q <= last_word ? BeIdle : BeRead;
          end
        end
        default: state_q <= BeIdle;
      endcase
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (start) begin
      src_q <= xfer_i.src;
      dst_q <= xfer_i.dst;
    end else if (word_done) begin
      src_q <= src_q + addr_t'(1);
      dst_q <= dst_q + addr_t'(1);
    end
    if (state_q == BeRwait && mem_rsp_i.rvalid) data_q <= mem_rsp_i.rdata;
  end

  always_comb begin
    mem_req_o = '0;
    case (state_q)
      BeRead: begin
        mem_req_o.strobe = 1'b1;
        mem_req_o.addr   = src_q;
      end
      BeWrite: begin
        mem_req_o.strobe = 1'b1;
        mem_req_o.we     = 1'b1;
        mem_req_o.addr   = dst_q;
        mem_req_o.wdata  = data_q;
      end
      default: ;
    endcase
  end

  assign xfer_busy_o = (state_q != BeIdle);
  assign xfer_done_o = (state_q == BeZero) || (word_done && last_word);

endmodule

//--- src/dma_desc_fetch.sv
////////////////////////////////////////////////////////////////////////////
// Descriptor fetch and chain walker. Reads four-word descriptors into a
// shadow register and hands them to the backend, prefetching the next one
// while a copy runs.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_desc_fetch (
  input  logic              i_idma_backend,
  input  logic              rst_n_i,
  input  logic              ptr_valid_i,
  input  dma_pkg::addr_t    ptr_i,
  output logic              ptr_pop_o,
  output dma_pkg::mem_req_t mem_req_o,
  input  logic              mem_gnt_i,
  input  dma_pkg::mem_rsp_t mem_rsp_i,
  output logic              xfer_start_o,
  output dma_pkg::xfer_t    xfer_o,
  input  logic              xfer_busy_i,
  input  logic              xfer_done_i,
  output logic              desc_done_o,
  output logic              desc_irq_o,
  output logic              busy_o
);
  import dma_pkg::*;

  typedef enum logic [1:0] {
    FeIdle,
    FeReq,
    FeWait
  } fe_state_e;

  fe_state_e  fe_state_q;
  logic [1:0] word_q;
  addr_t      desc_ptr_q;   // Descriptor being fetched
  addr_t      chain_q;      // Next pointer of the last fetched descriptor
  logic       shadow_full_q;
  logic       irq_q;        // Interrupt enable of the running transfer
  addr_t      src_q, dst_q;
  data_t      ctl_q;
  logic       take_chain, fetch_done;

  assign take_chain   = (fe_state_q == FeIdle) && !shadow_full_q && (chain_q != '0);
  assign ptr_pop_o    = (fe_state_q == FeIdle) && !shadow_full_q && (chain_q == '0)
                        && ptr_valid_i;
  assign fetch_done   = (fe_state_q == FeWait) && mem_rsp_i.rvalid && (word_q == DescNext);
  assign xfer_start_o = shadow_full_q && !xfer_busy_i;

  always_ff @(posedge i_idma_backend or negedge rst_n_i) begin
    if (!rst_n_i) begin
      fe_state_q    <= FeIdle;
      word_q        <= DescSrc;
      chain_q       <= '0;
      shadow_full_q <= 1'b0;
      irq_q         <= 1'b0;
    end else begin
      case (fe_state_q)
        FeIdle: begin
          if (take_chain || ptr_pop_o) begin
            fe_state_q <= FeReq;
            word_q     <= DescSrc;
          end
          if (take_chain) chain_q <= '0;
        end
        FeReq: if (mem_gnt_i) fe_state_q <= FeWait;
        FeWait: begin
          if (mem_rsp_i.rvalid) begin
            if (word_q == DescNext) begin
              chain_q    <= mem_rsp_i.rdata;
              fe_state_q <= FeIdle;
            end else begin
              word_q     <= word_q + 2'd1;
              fe_state_q <= FeReq;
            end
          end
        end
        default: fe_state_q <= FeIdle;
      endcase

      if (fetch_done) begin
        shadow_full_q <= 1'b1;
      end else if (xfer_start_o) begin
        shadow_full_q <= 1'b0;
      end
      if (xfer_start_o) irq_q <= ctl_q[DescIrqBit];
    end
  end

  // Descriptor shadow
  always_ff @(posedge i_idma_backend) begin
    if (take_chain) begin
      desc_ptr_q <= chain_q;
    end else if (ptr_pop_o) begin
      desc_ptr_q <= ptr_i;
    end
    if (fe_state_q == FeWait && mem_rsp_i.rvalid) begin
      case (word_q)
        DescSrc: src_q <= mem_rsp_i.rdata;
        DescDst: dst_q <= mem_rsp_i.rdata;
        DescCtl: ctl_q <= mem_rsp_i.rdata;
        default: ;
      endcase
    end
  end

  always_comb begin
    mem_req_o        = '0;
    mem_req_o.strobe = (fe_state_q == FeReq);
    mem_req_o.addr   = desc_ptr_q + addr_t'(word_q);
  end

  assign xfer_o.src  = src_q;
  assign xfer_o.dst  = dst_q;
  assign xfer_o.len  = ctl_q[LenWidth-1:0];
  assign desc_done_o = xfer_done_i;
  assign desc_irq_o  = irq_q;
  assign busy_o      = (fe_state_q != FeIdle) || shadow_full_q || xfer_busy_i
                       || (chain_q != '0);

endmodule

//--- src/dma_desc_regs.sv
////////////////////////////////////////////////////////////////////////////
// Register block of the DMA: pointer queue, completion counter, status
// word and level interrupt. Reads answer one cycle after the strobe.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_desc_regs #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic              i_idma_backend,
  input  logic              rst_n_i,
  input  dma_pkg::reg_req_t reg_req_i,
  output dma_pkg::reg_rsp_t reg_rsp_o,
  output logic              ptr_valid_o,
  output dma_pkg::addr_t    ptr_o,
  input  logic              ptr_pop_i,
  input  logic              busy_i,
  input  logic              desc_done_i,
  input  logic              desc_irq_i,
  output logic              irq_o
);
  import dma_pkg::*;

  localparam int unsigned IdxWidth   = (QueueDepth > 1) ? $clog2(QueueDepth) : 1;
  localparam int unsigned LevelWidth = $clog2(QueueDepth + 1);

  typedef logic [IdxWidth-1:0]   idx_t;
  typedef logic [LevelWidth-1:0] level_t;

  addr_t   queue_q [QueueDepth];
  idx_t    wr_idx_q, rd_idx_q;
  level_t  level_q;
  cnt_t    done_cnt_q;
  logic    irq_q;
  logic    rvalid_q;
  data_t   rdata_q, rdata_d;
  status_t status;
  logic    full, empty, push, pop, irq_clr;

  function automatic idx_t idx_inc(input idx_t idx);
    if (idx == idx_t'(QueueDepth - 1)) begin
      return '0;
    end
    return idx + idx_t'(1);
  endfunction

  assign full    = (level_q == level_t'(QueueDepth));
  assign empty   = (level_q == '0);
  assign push    = reg_req_i.wr && (reg_req_i.addr == RegDescAddr) && !full; // Dropped when full
  assign pop     = ptr_pop_i && !empty;
  assign irq_clr = reg_req_i.wr && (reg_req_i.addr == RegIrqClr);

  always_ff @(posedge i_idma_backend or negedge rst_n_i) begin
    if (!rst_n_i) begin
      wr_idx_q   <= '0;
      rd_idx_q   <= '0;
      level_q    <= '0;
      done_cnt_q <= '0;
      irq_q      <= 1'b0;
      rvalid_q   <= 1'b0;
    end else begin
      if (push) wr_idx_q <= idx_inc(wr_idx_q);
      if (pop) rd_idx_q <= idx_inc(rd_idx_q);
      if (push && !pop) begin
        level_q <= level_q + level_t'(1);
      end else if (pop && !push) begin
        level_q <= level_q - level_t'(1);
      end
      if (desc_done_i) done_cnt_q <= done_cnt_q + cnt_t'(1);
      // A new completion wins over a clear in the same cycle
      if (desc_done_i && desc_irq_i) begin
        irq_q <= 1'b1;
      end else if (irq_clr) begin
        irq_q <= 1'b0;
      end
      rvalid_q <= reg_req_i.rd;
    end
  end

  always_ff @(posedge i_idma_backend) begin
    if (push) queue_q[wr_idx_q] <= reg_req_i.wdata;
    if (reg_req_i.rd) rdata_q <= rdata_d;
  end

  always_comb begin
    status             = '0;
    status.busy        = busy_i;
    status.queue_full  = full;
    status.queue_empty = empty;
    status.irq         = irq_q;
    status.done_cnt    = done_cnt_q;
  end

  always_comb begin
    case (reg_req_i.addr)
      RegDescAddr: rdata_d = ptr_o;   // Head of the queue
      RegStatus:   rdata_d = status;
      RegIrqClr:   rdata_d = '0;
      RegDoneCnt:  rdata_d = data_t'(done_cnt_q);
      default:     rdata_d = '0;
    endcase
  end

  assign reg_rsp_o.rvalid = rvalid_q;
  assign reg_rsp_o.rdata  = rdata_q;
  assign ptr_valid_o      = !empty;
  assign ptr_o            = queue_q[rd_idx_q];
  assign irq_o            = irq_q;

endmodule

//--- src/dma_desc_top.sv
////////////////////////////////////////////////////////////////////////////
// Top level of the descriptor DMA. Connects the register block, fetch
// unit, copy backend and memory arbiter to the register and memory ports.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module dma_desc_top #(
  parameter int unsigned QueueDepth = 4
) (
  input  logic              i_idma_backend,
  input  logic              rst_n_i,
  input  dma_pkg::reg_req_t reg_req_i,
  output dma_pkg::reg_rsp_t reg_rsp_o,
  output dma_pkg::mem_req_t mem_req_o,
  input  dma_pkg::mem_rsp_t mem_rsp_i,
  output logic              irq_o
);
  import dma_pkg::*;

  // Pointer queue to fetch unit
  logic     ptr_valid, ptr_pop;
  addr_t    ptr;
  // Fetch unit to backend
  logic     xfer_start, xfer_busy, xfer_done;
  xfer_t    xfer;
  logic     desc_done, desc_irq, fetch_busy;
  // Per-master memory ports
  mem_req_t fe_req, be_req;
  mem_rsp_t fe_rsp, be_rsp;
  logic     fe_gnt, be_gnt;

  dma_desc_regs #(
    .QueueDepth ( QueueDepth )
  ) u_regs (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .reg_req_i      ( reg_req_i      ),
    .reg_rsp_o      ( reg_rsp_o      ),
    .ptr_valid_o    ( ptr_valid      ),
    .ptr_o          ( ptr            ),
    .ptr_pop_i      ( ptr_pop        ),
    .busy_i         ( fetch_busy     ),
    .desc_done_i    ( desc_done      ),
    .desc_irq_i     ( desc_irq       ),
    .irq_o          ( irq_o          )
  );

  dma_desc_fetch u_fetch (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .ptr_valid_i    ( ptr_valid      ),
    .ptr_i          ( ptr            ),
    .ptr_pop_o      ( ptr_pop        ),
    .mem_req_o      ( fe_req         ),
    .mem_gnt_i      ( fe_gnt         ),
    .mem_rsp_i      ( fe_rsp         ),
    .xfer_start_o   ( xfer_start     ),
    .xfer_o         ( xfer           ),
    .xfer_busy_i    ( xfer_busy      ),
    .xfer_done_i    ( xfer_done      ),
    .desc_done_o    ( desc_done      ),
    .desc_irq_o     ( desc_irq       ),
    .busy_o         ( fetch_busy     )
  );

  dma_backend u_backend (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .xfer_start_i   ( xfer_start     ),
    .xfer_i         ( xfer           ),
    .xfer_busy_o    ( xfer_busy      ),
    .xfer_done_o    ( xfer_done      ),
    .mem_req_o      ( be_req         ),
    .mem_gnt_i      ( be_gnt         ),
    .mem_rsp_i      ( be_rsp         )
  );

  dma_mem_arb u_arb (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n_i        ),
    .be_req_i       ( be_req         ),
    .be_gnt_o       ( be_gnt         ),
    .be_rsp_o       ( be_rsp         ),
    .fe_req_i       ( fe_req         ),
    .fe_gnt_o       ( fe_gnt         ),
    .fe_rsp_o       ( fe_rsp         ),
    .mem_req_o      ( mem_req_o      ),
    .mem_rsp_i      ( mem_rsp_i      )
  );

endmodule

//--- dv/tb_dma_desc.sv
////////////////////////////////////////////////////////////////////////////
// Testbench of the descriptor DMA. Reads commands and expected values from
// dv/dma_tests.txt, models the word memory and checks results per test.
////////////////////////////////////////////////////////////////////////////

`timescale 1ns/1ps

module tb_dma_desc;
  import dma_pkg::*;

  localparam int unsigned QueueDepth = 4;
  localparam int          WaitLimit  = 1000;
  localparam string       TestFile   = "dv/dma_tests.txt";

  logic     i_idma_backend;
  logic     rst_n;
  reg_req_t reg_req;
  reg_rsp_t reg_rsp;
  mem_req_t mem_req;
  mem_rsp_t mem_rsp, mem_rsp_next;
  logic     irq;

  data_t mem [addr_t];     // Memory model
  data_t exp_mem [addr_t]; // Expected contents
  int    errors, test_errors, tests, failed_tests;
  bit    timed_out;
  string test_name;

  dma_desc_top #(
    .QueueDepth ( QueueDepth )
  ) u_dut (
    .i_idma_backend ( i_idma_backend ),
    .rst_n_i        ( rst_n          ),
    .reg_req_i      ( reg_req        ),
    .reg_rsp_o      ( reg_rsp        ),
    .mem_req_o      ( mem_req        ),
    .mem_rsp_i      ( mem_rsp        ),
    .irq_o          ( irq            )
  );

  initial begin
    i_idma_backend = 1'b0;
    forever #50 i_idma_backend = ~i_idma_backend;
  end

  // Unwritten words read as a pattern of their address
  function automatic data_t fill_word(input addr_t addr);
    return addr ^ 32'h5a5a_5a5a;
  endfunction

  function automatic data_t mem_word(input addr_t addr);
    if (mem.exists(addr)) return mem[addr];
    return fill_word(addr);
  endfunction

  function automatic data_t exp_word(input addr_t addr);
    if (exp_mem.exists(addr)) return exp_mem[addr];
    return fill_word(addr);
  endfunction

  // Read returns one cycle after the strobe, writes land when sampled
  initial begin
    mem_rsp      = '0;
    mem_rsp_next = '0;
    forever begin
      @(negedge i_idma_backend);
      mem_rsp      = mem_rsp_next;
      mem_rsp_next = '0;
      if (mem_req.strobe) begin
        if (mem_req.we) begin
          mem[mem_req.addr] = mem_req.wdata;
        end else begin
          mem_rsp_next.rvalid = 1'b1;
          mem_rsp_next.rdata  = mem_word(mem_req.addr);
        end
      end
    end
  end

  task automatic check_mem(input addr_t addr, input data_t exp, input data_t got);
    if (got !== exp) begin
      $display("CHECK FAILED mem[%h]: expected %h, got %h", addr, exp, got);
      test_errors++;
    end
  endtask

  task automatic check_status(input status_t exp, input status_t got);
    if (got !== exp) begin
      $display("CHECK FAILED status: expected %h, got %h", exp, got);
      test_errors++;
    end
  endtask

  task automatic check_rdata(input reg_addr_t off, input data_t exp, input data_t got);
    if (got !== exp) begin
      $display("CHECK FAILED reg_rsp_o.rdata at %h: expected %h, got %h", off, exp, got);
      test_errors++;
    end
  endtask

  task automatic check_irq(input logic exp, input logic got);
    if (got !== exp) begin
      $display("CHECK FAILED irq_o: expected %h, got %h", exp, got);
      test_errors++;
    end
  endtask

  task automatic reg_write(input reg_addr_t off, input data_t wdata);
    reg_req       = '0;
    reg_req.wr    = 1'b1;
    reg_req.addr  = off;
    reg_req.wdata = wdata;
    @(negedge i_idma_backend);
    reg_req = '0;
  endtask

  task automatic reg_read(input reg_addr_t off, output data_t rdata);
    reg_req      = '0;
    reg_req.rd   = 1'b1;
    reg_req.addr = off;
    @(negedge i_idma_backend);
    reg_req = '0;
    rdata   = reg_rsp.rdata;
    if (reg_rsp.rvalid !== 1'b1) begin
      $display("ERROR: no read data one cycle after the read strobe at offset %0d", off);
      test_errors++;
    end
    @(negedge i_idma_backend);
    if (reg_rsp.rvalid !== 1'b0) begin
      $display("ERROR: read valid stayed high for more than one cycle at offset %0d", off);
      test_errors++;
    end
  endtask

  task automatic wait_done_cnt(input data_t target);
    data_t cnt;
    int    n;
    n = 0;
    reg_read(RegDoneCnt, cnt);
    while (cnt < target && n < WaitLimit) begin
      reg_read(RegDoneCnt, cnt);
      n++;
    end
    if (cnt < target) begin
      $display("ERROR: timeout, done count stuck at %0d instead of %0d", cnt, target);
      timed_out = 1'b1;
      test_errors++;
    end
  endtask

  task automatic wait_irq();
    int n;
    n = 0;
    while (irq !== 1'b1 && n < WaitLimit) begin
      @(negedge i_idma_backend);
      n++;
    end
    if (irq !== 1'b1) begin
      $display("ERROR: timeout, irq_o did not rise within %0d cycles", WaitLimit);
      timed_out = 1'b1;
      test_errors++;
    end
  endtask

  // Writes a descriptor and random source words; a copy is expected only if will_run
  task automatic place_desc(input addr_t ptr, input addr_t src, input addr_t dst,
                            input len_t len, input logic irq_en, input addr_t next,
                            input bit will_run);
    data_t ctl;
    data_t v;
    int    i;
    ctl                 = '0;
    ctl[LenWidth-1:0]   = len;
    ctl[DescIrqBit]     = irq_en;
    mem[ptr + addr_t'(DescSrc)]  = src;
    mem[ptr + addr_t'(DescDst)]  = dst;
    mem[ptr + addr_t'(DescCtl)]  = ctl;
    mem[ptr + addr_t'(DescNext)] = next;
    for (i = 0; i < int'(len); i++) begin
      v = $urandom;
      mem[src + addr_t'(i)]     = v;
      exp_mem[src + addr_t'(i)] = v;
      if (will_run) exp_mem[dst + addr_t'(i)] = v;
    end
  endtask

  task automatic end_test();
    if (test_name != "") begin
      $display("test %0s: %0s, %0d errors", test_name,
               (test_errors == 0) ? "passed" : "FAILED", test_errors);
      tests++;
      if (test_errors != 0) failed_tests++;
      errors += test_errors;
    end
    test_errors = 0;
  endtask

  task automatic run_command(input string line);
    string cmd;
    string name;
    data_t a0, a1, a2, a3, a4, a5;
    data_t got;
    int    n;
    int    i;
    a0 = '0;
    a1 = '0;
    a2 = '0;
    a3 = '0;
    a4 = '0;
    a5 = '0;
    n  = $sscanf(line, "%s %h %h %h %h %h %h", cmd, a0, a1, a2, a3, a4, a5);
    if (cmd == "T") begin
      n = $sscanf(line, "%s %s", cmd, name);
      end_test();
      test_name = name;
    end else if (cmd == "D" || cmd == "N") begin
      place_desc(a0, a1, a2, len_t'(a3), a4[0], a5, cmd == "D");
    end else if (cmd == "P") begin
      reg_write(RegDescAddr, a0);
    end else if (cmd == "K") begin
      reg_write(RegIrqClr, '0);
    end else if (cmd == "W") begin
      wait_done_cnt(a0);
    end else if (cmd == "I") begin
      wait_irq();
    end else if (cmd == "R") begin
      reg_read(reg_addr_t'(a0), got);
      check_rdata(reg_addr_t'(a0), a1, got);
    end else if (cmd == "S") begin
      reg_read(RegStatus, got);
      check_status(status_t'(a0), status_t'(got));
    end else if (cmd == "Q") begin
      check_irq(a0[0], irq);
    end else if (cmd == "M") begin
      for (i = 0; i < int'(a1); i++) begin
        check_mem(a0 + addr_t'(i), exp_word(a0 + addr_t'(i)), mem_word(a0 + addr_t'(i)));
      end
    end else begin
      $display("ERROR: unknown command in test file: %0s", line);
      test_errors++;
    end
  endtask

  initial begin
    int unsigned seed;
    int          fd;
    string       line;
    seed         = $urandom(22599);
    reg_req      = '0;
    rst_n        = 1'b0;
    errors       = 0;
    test_errors  = 0;
    tests        = 0;
    failed_tests = 0;
    timed_out    = 1'b0;
    test_name    = "";
    repeat (3) @(negedge i_idma_backend);
    rst_n = 1'b1;

    fd = $fopen(TestFile, "r");
    if (fd == 0) begin
      $display("ERROR: cannot open the test file %0s", TestFile);
      errors++;
    end else begin
      while (!timed_out && $fgets(line, fd) != 0) begin
        if (line.len() > 1 && line.getc(0) != 8'h23) run_command(line); // Skip comments
      end
      $fclose(fd);
    end
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests, failed_tests, errors);
    if (errors == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

//--- dv/dma_tests.txt
# Hex columns. T name | D ptr src dst len irq next (N: placed, must not run) | P ptr
# W done_cnt | I | K | Q irq | R offset data | S status | M dst words
T reset
S 20000000
R 3 00000000
T single
D 100 1000 2000 8 0 0
P 100
W 1
M 2000 8
S 20000001
T chain
D 200 1100 2100 5 0 210
D 210 1200 2200 3 0 220
D 220 1300 2300 6 0 0
P 200
W 4
M 2100 5
M 2200 3
M 2300 6
R 3 00000004
S 20000004
T irq
D 300 1400 2400 4 0 0
P 300
W 5
Q 0
S 20000005
D 310 1500 2500 4 1 0
P 310
I
W 6
M 2400 4
M 2500 4
S 30000006
K
Q 0
S 20000006
T zero
D 400 1600 2600 0 0 0
P 400
W 7
M 2600 4
S 20000007
T qfull
D 500 1700 2700 28 0 0
D 510 1800 2800 3 0 0
D 520 1900 2900 3 0 0
D 530 1a00 2a00 3 0 0
D 540 1b00 2b00 3 0 0
N 550 1c00 2c00 3 0 0
P 500
P 510
P 520
P 530
P 540
P 550
S c0000007
W c
M 2700 28
M 2800 3
M 2900 3
M 2a00 3
M 2b00 3
M 2c00 3
R 3 0000000c
S 2000000c

//--- list.f
src/dma_pkg.sv
src/dma_mem_arb.sv
src/dma_backend.sv
src/dma_desc_fetch.sv
src/dma_desc_regs.sv
src/dma_desc_top.sv
dv/tb_dma_desc.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Builds the testbench with Verilator, runs it, and looks for the pass message in the log
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing --top-module tb_dma_desc -Mdir obj_dir -f list.f \
  && ./obj_dir/Vtb_dma_desc > sim.log 2>&1 \
  || { echo "build or simulation run failed"; exit 1; }
cat sim.log
grep -qx "Everything OK" sim.log && echo "RESULT: pass" || { echo "RESULT: fail"; exit 1; }
